//--- dac_tx.f
verilog/dac_tx_pkg.sv
verilog/dac_tx_regs.sv
verilog/dac_tx_channel.sv
verilog/dac_tx_if.sv
verilog/dac_tx_top.sv
tb/dac_tx_assert.sv
tb/dac_tx_tb.sv

//--- Makefile
# Verilator lint and simulation of the dac_tx transmit datapath

TOP := dac_tx_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module dac_tx_top \
	  verilog/dac_tx_pkg.sv verilog/dac_tx_regs.sv verilog/dac_tx_channel.sv \
	  verilog/dac_tx_if.sv verilog/dac_tx_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f dac_tx.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f dac_tx.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
	  echo "Simulation FAILED"; \
	  exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/dac_tx_tb.sv
// Testbench for the DAC transmit datapath with bus tasks, a reference model and a word checker

`timescale 1ns/1ps

module dac_tx_tb
  import dac_tx_pkg::*;
();

  // ***************************************************************************
  // Run constants
  // ***************************************************************************

  localparam int dev_type   = 0;
  localparam int clk_period = 100;
  localparam int drive_dly  = 5;
  localparam int seed       = 30121;
  localparam int check_len  = 40;
  localparam int ack_limit  = 16;

  // An access takes two cycles, a window its length plus two cycles of latency.
  // Reset and a margin come on top
  localparam int num_access      = 80;
  localparam int num_window      = 8;
  localparam int watchdog_cycles = 5 + 2 * num_access + num_window * (check_len + 2) + 100;

  // Bit positions inside the link word
  localparam int half_bits  = samples_per_clk * sample_width;
  localparam int group_bits = half_bits / 2;
  localparam int byte_bits  = sample_width / 2;

  logic                     dac_clk;
  logic                     dac_rst;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [wb_addr_width-1:0] wb_adr;
  logic [wb_data_width-1:0] wb_dat_w;
  logic [wb_data_width-1:0] wb_dat_r;
  logic                     wb_ack;
  logic [link_width-1:0]    tx_data;

  // Model of the programmed state and the check window
  int        cyc_cnt = 0;
  int        last_ack_cyc;
  int        ack_cyc;
  bit        chk_on = 1'b0;
  logic      m_en;
  chan_cfg_t m_cfg0;
  chan_cfg_t m_cfg1;

  string cur_test;
  int    test_errs = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;

  dac_tx_top #(
    .device_type (dev_type)
  ) dut0 (
    .dac_clk  (dac_clk),
    .dac_rst  (dac_rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .tx_data  (tx_data)
  );

  initial begin
    dac_clk = 1'b0;
    forever #(clk_period / 2) dac_clk = ~dac_clk;
  end

  // Counts rising edges so the checker knows the cycle index since an ack
  always @(posedge dac_clk) cyc_cnt <= cyc_cnt + 1;

  // ***************************************************************************
  // Reference model
  // ***************************************************************************

  // Expected link word for cycle idx after enable, built from the packing rule
  function automatic logic [link_width-1:0] ref_link_word(input logic en, input chan_cfg_t c0,
                                                          input chan_cfg_t c1, input int idx);
    logic [link_width-1:0]   word;
    logic [sample_width-1:0] smp [num_channels][samples_per_clk];
    chan_cfg_t               cfg;
    int                      src;
    int                      pos;
    word = '0;
    for (int c = 0; c < num_channels; c++) begin
      cfg = (c == 0) ? c0 : c1;
      for (int j = 0; j < samples_per_clk; j++) begin
        if (en && cfg.mode == src_const) begin
          smp[c][j] = cfg.pattern;
        end else if (en && cfg.mode == src_ramp) begin
          // Slot j of block idx is ramp step 4*idx+j, wrapping at 16 bits
          smp[c][j] = 16'((idx * samples_per_clk + j) * int'(cfg.step));
        end else begin
          smp[c][j] = '0;
        end
      end
      // Lane k counts from the top byte of a group, low bytes in the upper group
      for (int k = 0; k < samples_per_clk; k++) begin
        src = (dev_type == 1) ? k : samples_per_clk - 1 - k;
        pos = c * half_bits + (samples_per_clk - 1 - k) * byte_bits;
        word[pos + group_bits +: byte_bits] = smp[c][src][byte_bits-1:0];
        word[pos +: byte_bits]              = smp[c][src][sample_width-1:byte_bits];
      end
    end
    return word;
  endfunction

  // Bits that a register really holds
  function automatic logic [wb_data_width-1:0] field_mask(input reg_addr_e a);
    case (a)
      reg_ctrl:                   return 32'h0000_0001;
      reg_ch0_mode, reg_ch1_mode: return 32'h0000_0003;
      reg_version:                return 32'h0000_0000;
      default:                    return 32'h0000_ffff;
    endcase
  endfunction

  function automatic chan_cfg_t make_cfg(input src_mode_e mode);
    chan_cfg_t cfg;
    cfg.mode    = mode;
    // A pattern is never zero and a step is big enough to wrap inside one window
    cfg.pattern = 16'($urandom) | 16'h0001;
    cfg.step    = 16'($urandom) | 16'h0400;
    return cfg;
  endfunction

  task automatic check_value(input string name, input logic [link_width-1:0] expected,
                             input logic [link_width-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      test_errs++;
    end
  endtask

  // Every cycle of an open window is compared once the two cycles of latency are over
  always @(negedge dac_clk) begin
    if (chk_on && cyc_cnt >= ack_cyc + 2) begin
      check_value(cur_test, ref_link_word(m_en, m_cfg0, m_cfg1, cyc_cnt - ack_cyc - 2),
                  tx_data);
    end
  end

  // ***************************************************************************
  // Wishbone master
  // ***************************************************************************

  task automatic wait_for_ack(input string what);
    int waited;
    waited = 0;
    do begin
      @(posedge dac_clk);
      #drive_dly;
      waited++;
    end while (!wb_ack && waited < ack_limit);
    if (!wb_ack) begin
      $display("%s got no Wishbone acknowledge within %0d cycles", what, ack_limit);
      test_errs++;
    end
    last_ack_cyc = cyc_cnt;
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [wb_data_width-1:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = a;
    wb_dat_w = data;
    wait_for_ack("Register write");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_e a, output logic [wb_data_width-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = a;
    wait_for_ack("Register read");
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // ***************************************************************************
  // Test steps
  // ***************************************************************************

  // Channels are set up with the core disabled, enable follows in run_window
  task automatic program_channels(input chan_cfg_t c0, input chan_cfg_t c1);
    write_reg(reg_ctrl, 32'h0);
    write_reg(reg_ch0_mode, 32'(c0.mode));
    write_reg(reg_ch0_pattern, 32'(c0.pattern));
    write_reg(reg_ch0_step, 32'(c0.step));
    write_reg(reg_ch1_mode, 32'(c1.mode));
    write_reg(reg_ch1_pattern, 32'(c1.pattern));
    write_reg(reg_ch1_step, 32'(c1.step));
    m_cfg0 = c0;
    m_cfg1 = c1;
  endtask

  task automatic run_window(input logic en, input int cycles);
    write_reg(reg_ctrl, {31'b0, en});
    m_en    = en;
    ack_cyc = last_ack_cyc;
    chk_on  = 1'b1;
    repeat (cycles + 2) @(posedge dac_clk);
    #drive_dly;
    chk_on = 1'b0;
  endtask

  task automatic open_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      $display("PASS %s", cur_test);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", cur_test, test_errs);
      fail_cnt++;
    end
  endtask

  initial begin
    logic [wb_data_width-1:0] rd;
    logic [wb_data_width-1:0] wr;
    reg_addr_e                a;
    dac_rst  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    void'($urandom(seed));
    repeat (5) @(posedge dac_clk);
    #drive_dly;
    dac_rst = 1'b0;

    open_test("reset_state");
    check_value(cur_test, '0, tx_data);
    for (int i = 0; i < 7; i++) begin
      read_reg(reg_addr_e'(3'(i)), rd);
      check_value(cur_test, '0, 128'(rd));
    end
    close_test();

    // Random values confined to each register's field read back unchanged
    open_test("register_access");
    for (int i = 0; i < 7; i++) begin
      a  = reg_addr_e'(3'(i));
      wr = $urandom & field_mask(a);
      write_reg(a, wr);
      read_reg(a, rd);
      check_value(cur_test, 128'(wr), 128'(rd));
    end
    read_reg(reg_version, rd);
    check_value(cur_test, 128'(core_version), 128'(rd));
    write_reg(reg_version, $urandom);
    read_reg(reg_version, rd);
    check_value(cur_test, 128'(core_version), 128'(rd));
    close_test();

    open_test("constant_mode");
    program_channels(make_cfg(src_const), make_cfg(src_const));
    run_window(1'b1, check_len);
    close_test();

    // Ramp on each channel in turn, the other one constant
    open_test("ramp_mode");
    program_channels(make_cfg(src_ramp), make_cfg(src_const));
    run_window(1'b1, check_len);
    program_channels(make_cfg(src_const), make_cfg(src_ramp));
    run_window(1'b1, check_len);
    close_test();

    // The ramp is still running here, re-enable must restart it at 0
    open_test("disable");
    run_window(1'b0, check_len / 4);
    run_window(1'b1, check_len);
    close_test();

    open_test("zero_channel");
    program_channels(make_cfg(src_zero), make_cfg(src_const));
    run_window(1'b1, check_len / 2);
    program_channels(make_cfg(src_const), make_cfg(src_zero));
    run_window(1'b1, check_len / 2);
    close_test();

    // The bound Wishbone checker keeps its own count of failed assertions
    open_test("bus_assertions");
    test_errs = dut0.regs_inst.regs_chk.err_cnt;
    close_test();

    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Ends a run that hangs, for instance on a missing acknowledge
  initial begin
    repeat (watchdog_cycles) @(posedge dac_clk);
    $display("Timeout, the tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- tb/dac_tx_assert.sv
// Wishbone acknowledge and reset checks bound into the DAC transmit control block

`timescale 1ns/1ps

module dac_tx_assert (
  input logic dac_clk,
  input logic dac_rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic enable
);

  // Number of failed assertions, the testbench picks it up at the end of the run
  int err_cnt = 0;

  // The acknowledge is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge dac_clk) disable iff (dac_rst)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack stayed high for more than one cycle");
      err_cnt++;
    end

  // Every acknowledge answers a request that was present on the previous edge
  ack_after_request: assert property (@(posedge dac_clk) disable iff (dac_rst)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
      $error("wb_ack rose without wb_cyc and wb_stb high");
      err_cnt++;
    end

  // Reset leaves the core disabled with no access pending
  idle_after_reset: assert property (@(posedge dac_clk)
    $fell(dac_rst) |-> !enable && !wb_ack)
    else begin
      $error("enable or wb_ack high in the cycle after reset");
      err_cnt++;
    end

endmodule

bind dac_tx_regs dac_tx_assert regs_chk (
  .dac_clk (dac_clk),
  .dac_rst (dac_rst),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .enable  (enable)
);

//--- verilog/dac_tx_top.sv
// DAC transmit top level joining the register block, two sample channels and the link interface

`timescale 1ns/1ps

module dac_tx_top
  import dac_tx_pkg::*;
#(
  // Device family of the link byte order
  parameter int device_type = 0
) (
  input  logic                     dac_clk,
  input  logic                     dac_rst,

  // Register bus
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_addr_width-1:0] wb_adr,
  input  logic [wb_data_width-1:0] wb_dat_w,
  output logic [wb_data_width-1:0] wb_dat_r,
  output logic                     wb_ack,

  // JESD transmit word
  output logic [link_width-1:0]    tx_data
);

  // Settings from the control block
  logic      enable;
  chan_cfg_t cfg0;
  chan_cfg_t cfg1;

  // Sample blocks of each channel
  sample_blk_t blk0;
  sample_blk_t blk1;

  // Register bus and settings
  dac_tx_regs regs_inst (
    .dac_clk  (dac_clk),
    .dac_rst  (dac_rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .enable   (enable),
    .cfg0     (cfg0),
    .cfg1     (cfg1)
  );

  // One sample source per channel, each one cycle behind the registers
  dac_tx_channel ch0_inst (
    .dac_clk (dac_clk),
    .dac_rst (dac_rst),
    .enable  (enable),
    .cfg     (cfg0),
    .samples (blk0)
  );

  dac_tx_channel ch1_inst (
    .dac_clk (dac_clk),
    .dac_rst (dac_rst),
    .enable  (enable),
    .cfg     (cfg1),
    .samples (blk1)
  );

  // Link word packing adds the second cycle of latency
  dac_tx_if #(
    .device_type (device_type)
  ) if_inst (
    .dac_clk (dac_clk),
    .dac_rst (dac_rst),
    .ch0     (blk0),
    .ch1     (blk1),
    .tx_data (tx_data)
  );

endmodule

//--- verilog/dac_tx_if.sv
// DAC transmit physical interface, registers both channels and packs their bytes into the link word

`timescale 1ns/1ps

module dac_tx_if
  import dac_tx_pkg::*;
#(
  // Byte order of the device family, 1 lists s0 first and 0 lists s3 first
  parameter int device_type = 0
) (
  input  logic                  dac_clk,
  input  logic                  dac_rst,
  input  sample_blk_t           ch0,
  input  sample_blk_t           ch1,
  output logic [link_width-1:0] tx_data
);

  // Both blocks as one array; within a channel s0 lands at the highest index
  logic [num_channels-1:0][samples_per_clk-1:0][sample_width-1:0] smp;

  wire [link_width-1:0] link_next;

  assign smp[0] = ch0;
  assign smp[1] = ch1;

  // ***************************************************************************
  // Byte reorder
  // ***************************************************************************

  // Each channel owns one half of the word, channel 1 the upper one.
  // In a half, the upper group holds the low bytes and the lower group the
  // high bytes. Lane k counts from the top byte of a group down
  for (genvar c = 0; c < num_channels; c++) begin : g_chan
    for (genvar k = 0; k < samples_per_clk; k++) begin : g_lane
      // Device family 1 puts s(k) on lane k and family 0 puts s(3-k) there.
      // Sample s(j) is found at array index samples_per_clk-1-j
      assign link_next[c*samples_per_clk*sample_width +
                       samples_per_clk*sample_width/2 +
                       (samples_per_clk-1-k)*(sample_width/2) +: sample_width/2] =
        (device_type == 1) ? smp[c][samples_per_clk-1-k][sample_width/2-1:0]
                           : smp[c][k][sample_width/2-1:0];

      assign link_next[c*samples_per_clk*sample_width +
                       (samples_per_clk-1-k)*(sample_width/2) +: sample_width/2] =
        (device_type == 1) ? smp[c][samples_per_clk-1-k][sample_width-1:sample_width/2]
                           : smp[c][k][sample_width-1:sample_width/2];
    end
  end

  // ***************************************************************************
  // Link word register
  // ***************************************************************************

  // The link takes one word every clock, so the word is simply registered
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      tx_data <= '0;
    end else begin
      tx_data <= link_next;
    end
  end

endmodule

//--- verilog/dac_tx_channel.sv
// DAC transmit channel, a sample source producing four zero, constant or ramp samples per clock

`timescale 1ns/1ps

module dac_tx_channel
  import dac_tx_pkg::*;
(
  input  logic        dac_clk,
  input  logic        dac_rst,
  input  logic        enable,
  input  chan_cfg_t   cfg,
  output sample_blk_t samples
);

  // Ramp value of the earliest sample in the current block
  logic [sample_width-1:0] ramp_base;

  // Ramp values of the four sample slots, index 0 is the earliest
  logic [samples_per_clk-1:0][sample_width-1:0] ramp_val;

  // Running offset from the base; it ends at four steps once the loop is done
  logic [sample_width-1:0] ramp_off;

  sample_blk_t blk_next;

  // ***************************************************************************
  // Ramp offsets
  // ***************************************************************************

  // Each slot adds one more step to the base, all sums wrap modulo 2^16
  always_comb begin
    ramp_off = '0;
    for (int i = 0; i < samples_per_clk; i++) begin
      ramp_val[i] = ramp_base + ramp_off;
      ramp_off    = ramp_off + cfg.step;
    end
  end

  // ***************************************************************************
  // Source select
  // ***************************************************************************

  // A disabled channel sends zeros whatever its mode
  always_comb begin
    blk_next = '0;
    if (enable) begin
      case (cfg.mode)
        src_const: begin
          blk_next.s0 = cfg.pattern;
          blk_next.s1 = cfg.pattern;
          blk_next.s2 = cfg.pattern;
          blk_next.s3 = cfg.pattern;
        end
        src_ramp: begin
          blk_next.s0 = ramp_val[0];
          blk_next.s1 = ramp_val[1];
          blk_next.s2 = ramp_val[2];
          blk_next.s3 = ramp_val[3];
        end
        // Zero mode and the unused code
        default: blk_next = '0;
      endcase
    end
  end

  // ***************************************************************************
  // Registers
  // ***************************************************************************

  // The base sits at zero while disabled, so the first enabled block starts
  // at 0 and every later block moves on by four steps
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      ramp_base <= '0;
    end else if (!enable) begin
      ramp_base <= '0;
    end else begin
      ramp_base <= ramp_base + ramp_off;
    end
  end

  // Sample block register gives the one cycle latency from enable and cfg
  always_ff @(posedge dac_clk) begin
    samples <= blk_next;
  end

endmodule

//--- verilog/dac_tx_regs.sv
// DAC transmit control block, a Wishbone classic slave holding enable and channel settings

`timescale 1ns/1ps

module dac_tx_regs
  import dac_tx_pkg::*;
(
  input  logic                     dac_clk,
  input  logic                     dac_rst,

  // Wishbone classic slave
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_addr_width-1:0] wb_adr,
  input  logic [wb_data_width-1:0] wb_dat_w,
  output logic [wb_data_width-1:0] wb_dat_r,
  output logic                     wb_ack,

  // Settings towards the channels
  output logic                     enable,
  output chan_cfg_t                cfg0,
  output chan_cfg_t                cfg1
);

  // A new request is taken only while no acknowledge is pending, which keeps
  // the acknowledge one cycle wide and low for at least one cycle after it
  logic                     access;
  reg_addr_e                addr;
  logic [wb_data_width-1:0] rd_data;

  assign access = wb_cyc & wb_stb & ~wb_ack;
  assign addr   = reg_addr_e'(wb_adr);

  // ***************************************************************************
  // Acknowledge and register writes
  // ***************************************************************************

  // The write lands on the same edge that raises the acknowledge
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      wb_ack <= 1'b0;
      enable <= 1'b0;
      cfg0   <= '0;
      cfg1   <= '0;
    end else begin
      wb_ack <= access;
      if (access && wb_we) begin
        case (addr)
          reg_ctrl:        enable       <= wb_dat_w[0];
          reg_ch0_mode:    cfg0.mode    <= src_mode_e'(wb_dat_w[1:0]);
          reg_ch0_pattern: cfg0.pattern <= wb_dat_w[sample_width-1:0];
          reg_ch0_step:    cfg0.step    <= wb_dat_w[sample_width-1:0];
          reg_ch1_mode:    cfg1.mode    <= src_mode_e'(wb_dat_w[1:0]);
          reg_ch1_pattern: cfg1.pattern <= wb_dat_w[sample_width-1:0];
          reg_ch1_step:    cfg1.step    <= wb_dat_w[sample_width-1:0];
          // The version word is read only
          default: ;
        endcase
      end
    end
  end

  // ***************************************************************************
  // Read-back
  // ***************************************************************************

  // Unused bits of every register read as zero
  always_comb begin
    rd_data = '0;
    case (addr)
      reg_ctrl:        rd_data[0]                = enable;
      reg_ch0_mode:    rd_data[1:0]              = cfg0.mode;
      reg_ch0_pattern: rd_data[sample_width-1:0] = cfg0.pattern;
      reg_ch0_step:    rd_data[sample_width-1:0] = cfg0.step;
      reg_ch1_mode:    rd_data[1:0]              = cfg1.mode;
      reg_ch1_pattern: rd_data[sample_width-1:0] = cfg1.pattern;
      reg_ch1_step:    rd_data[sample_width-1:0] = cfg1.step;
      reg_version:     rd_data                   = core_version;
      default:         rd_data                   = '0;
    endcase
  end

  // Read data is captured with the access and is valid while wb_ack is high
  always_ff @(posedge dac_clk) begin
    if (access) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

//--- verilog/dac_tx_pkg.sv
// DAC transmit package with shared sizes, register map, source modes and sample types

package dac_tx_pkg;

  // ***************************************************************************
  // Datapath and bus sizes
  // ***************************************************************************

  // One DAC sample and the number of samples each channel delivers per clock
  localparam int sample_width    = 16;
  localparam int samples_per_clk = 4;
  localparam int num_channels    = 2;

  // The JESD transmit word carries every sample of every channel
  localparam int link_width      = 128;

  // Register bus is word addressed
  localparam int wb_addr_width   = 3;
  localparam int wb_data_width   = 32;

  // Value returned at the version address (major.minor.patch in the low three bytes)
  localparam logic [31:0] core_version = 32'h0001_0200;

  // ***************************************************************************
  // Encodings
  // ***************************************************************************

  // Per-channel sample source; the unused code 3 behaves as zero
  typedef enum logic [1:0] {
    src_zero  = 2'd0,
    src_const = 2'd1,
    src_ramp  = 2'd2
  } src_mode_e;

  // Register word addresses
  typedef enum logic [2:0] {
    reg_ctrl        = 3'd0,
    reg_ch0_mode    = 3'd1,
    reg_ch0_pattern = 3'd2,
    reg_ch0_step    = 3'd3,
    reg_ch1_mode    = 3'd4,
    reg_ch1_pattern = 3'd5,
    reg_ch1_step    = 3'd6,
    reg_version     = 3'd7
  } reg_addr_e;

  // Channel configuration as held by the control block
  typedef struct packed {
    src_mode_e               mode;
    logic [sample_width-1:0] pattern;
    logic [sample_width-1:0] step;
  } chan_cfg_t;

  // Four samples of one channel, s0 is the earliest in time
  typedef struct packed {
    logic [sample_width-1:0] s0;
    logic [sample_width-1:0] s1;
    logic [sample_width-1:0] s2;
    logic [sample_width-1:0] s3;
  } sample_blk_t;

endpackage
